/* common/usb_serial_pkg.sv */
//--------------------------------------------------------------------------
// usb serial shared definitions
// buffer and packet sizes, byte-level types and the abstract host-link
// structs used by the bridge and its test environment
//--------------------------------------------------------------------------

package usb_serial_pkg;

    //----------------------------------------------------------------------
    // sizes
    //----------------------------------------------------------------------

    localparam int ASIZE   = 10;                // send buffer depth = 2**ASIZE
    localparam int MAX_PKT = 32;                // largest IN payload in bytes

    //----------------------------------------------------------------------
    // plain vector types
    //----------------------------------------------------------------------

    typedef logic [7:0]       byte_t;           // one data byte
    typedef logic [ASIZE:0]   ptr_t;            // buffer pointer, msb is wrap bit
    typedef logic [ASIZE:0]   cnt_t;            // bytes in buffer, 0..1024
    typedef logic [5:0]       pkt_len_t;        // bytes in one packet, 0..32

    //----------------------------------------------------------------------
    // host link, IN endpoint
    //----------------------------------------------------------------------

    typedef struct packed {
        logic  in_tok;                          // IN token, one cycle
        logic  in_ack;                          // host ACK for last IN packet
    } in_host_t;

    typedef struct packed {
        logic  nak;                             // nothing to send, one cycle
        logic  valid;                           // data byte present
        logic  last;                            // final byte of packet
        logic  toggle;                          // DATA0 / DATA1
        byte_t data;
    } in_rsp_t;

    //----------------------------------------------------------------------
    // host link, OUT endpoint
    //----------------------------------------------------------------------

    typedef struct packed {
        logic  valid;                           // data byte present
        logic  last;                            // final byte of packet
        logic  toggle;                          // DATA0 / DATA1 of this packet
        byte_t data;
    } out_pkt_t;

endpackage

/* design/send_buffer.sv */
//--------------------------------------------------------------------------
// send buffer
// 1024-byte device-to-host FIFO; the read side is speculative so a packet
// can be re-read until the host acknowledges it
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module send_buffer (
    input  logic                  clk,
    input  logic                  usb_rstn,
    // local write side
    input  usb_serial_pkg::byte_t send_data,
    input  logic                  send_valid,
    output logic                  send_ready,
    // packetizer read side
    input  logic                  rd_en,        // take one byte, spec pointer moves
    output usb_serial_pkg::byte_t rd_data,      // valid the cycle after rd_en
    input  logic                  rewind,       // spec pointer back to committed
    input  logic                  commit,       // spec pointer becomes committed
    output usb_serial_pkg::cnt_t  avail         // bytes not yet read speculatively
);
    import usb_serial_pkg::*;

    //----------------------------------------------------------------------
    // storage and pointers
    //----------------------------------------------------------------------

    byte_t mem [0:(1<<ASIZE)-1];                // maps to block ram

    ptr_t  wptr;                                // next write slot
    ptr_t  cptr;                                // oldest unacked byte
    ptr_t  sptr;                                // next byte to hand out
    logic  wr_fire;

    assign wr_fire = send_valid && send_ready;

    // full when writer is a whole lap ahead of the committed reader
    assign send_ready = (wptr != {~cptr[ASIZE], cptr[ASIZE-1:0]});

    // counted against spec pointer, so unacked bytes are not offered twice
    assign avail = cnt_t'(wptr - sptr);

    //----------------------------------------------------------------------
    // write side
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            wptr <= '0;
        end else if (wr_fire) begin
            wptr <= wptr + ptr_t'(1);           // wrap bit toggles every lap
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wptr[ASIZE-1:0]] <= send_data;
        end
    end

    //----------------------------------------------------------------------
    // read side
    //----------------------------------------------------------------------

    // committed pointer, only moves on host ACK
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            cptr <= '0;
        end else if (commit) begin
            cptr <= sptr;                       // free bytes of acked packet
        end
    end

    // speculative pointer
    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            sptr <= '0;
        end else if (rewind) begin
            sptr <= cptr;                       // resend from oldest unacked
        end else if (rd_en) begin
            sptr <= sptr + ptr_t'(1);
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[sptr[ASIZE-1:0]];
        end
    end

endmodule

/* design/in_packetizer.sv */
//--------------------------------------------------------------------------
// IN packetizer
// answers IN tokens with NAK or a data packet from the send buffer and
// runs the ACK / retry / data toggle rules of the bulk IN endpoint
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module in_packetizer (
    input  logic                     clk,
    input  logic                     usb_rstn,
    // host link
    input  usb_serial_pkg::in_host_t host,
    output usb_serial_pkg::in_rsp_t  rsp,
    // send buffer
    input  usb_serial_pkg::cnt_t     avail,
    output logic                     rd_en,
    input  usb_serial_pkg::byte_t    rd_data,
    output logic                     rewind,
    output logic                     commit
);
    import usb_serial_pkg::*;

    typedef enum logic [1:0] {
        IDLE,                                   // wait for token
        READ,                                   // first buffer read, no byte out yet
        SEND,                                   // bytes on the link
        WAIT_ACK                                // packet out, ACK or retry token
    } in_state_t;

    in_state_t state;
    in_state_t state_nxt;

    pkt_len_t  pkt_len;                         // length of packet in flight
    pkt_len_t  rd_left;                         // reads still to issue
    pkt_len_t  len_new;                         // length for a fresh packet
    logic      has_data;
    logic      tok_new;                         // token that starts a new packet
    logic      tok_retry;                       // token with previous packet unacked
    logic      tog;                             // current IN data toggle
    logic      nak_q;
    logic      valid_q;
    logic      last_q;

    //----------------------------------------------------------------------
    // token decode
    //----------------------------------------------------------------------

    assign has_data  = (avail != '0);
    assign len_new   = (avail >= cnt_t'(MAX_PKT)) ? pkt_len_t'(MAX_PKT) : pkt_len_t'(avail);
    assign tok_new   = host.in_tok && (state == IDLE);
    assign commit    = host.in_ack && (state == WAIT_ACK);
    assign tok_retry = host.in_tok && (state == WAIT_ACK) && !host.in_ack; // ack wins
    assign rewind    = tok_retry;               // same bytes again

    // one read per byte, back to back
    assign rd_en = (state == READ) || ((state == SEND) && (rd_left != '0));

    //----------------------------------------------------------------------
    // state machine
    //----------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (tok_new && has_data) state_nxt = READ;
            READ:     state_nxt = SEND;
            SEND:     if (last_q) state_nxt = WAIT_ACK;       // final byte on link now
            WAIT_ACK: begin
                if (commit) begin
                    state_nxt = IDLE;
                end else if (tok_retry) begin
                    state_nxt = READ;
                end
            end
            default:  state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            state   <= IDLE;
            pkt_len <= '0;
            rd_left <= '0;
            tog     <= 1'b0;                    // DATA0 after reset
            nak_q   <= 1'b0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            state   <= state_nxt;
            nak_q   <= tok_new && !has_data;    // empty, NAK next cycle
            valid_q <= rd_en;                   // byte follows its read by one cycle
            last_q  <= rd_en && (rd_left == pkt_len_t'(1));
            if (tok_new && has_data) begin
                pkt_len <= len_new;             // kept for a possible retry
                rd_left <= len_new;
            end else if (tok_retry) begin
                rd_left <= pkt_len;             // resend unchanged
            end else if (rd_en) begin
                rd_left <= rd_left - pkt_len_t'(1);
            end
            if (commit) begin
                tog <= ~tog;                    // flips only on ACK
            end
        end
    end

    //----------------------------------------------------------------------
    // response to host
    //----------------------------------------------------------------------

    always_comb begin
        rsp.nak    = nak_q;
        rsp.valid  = valid_q;
        rsp.last   = last_q;
        rsp.toggle = tog;                       // steady for whole packet
        rsp.data   = rd_data;                   // straight from buffer register
    end

endmodule

/* design/out_receiver.sv */
//--------------------------------------------------------------------------
// OUT receiver
// checks the OUT data toggle, forwards fresh bytes as a strobe and
// acknowledges every packet, duplicates included
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module out_receiver (
    input  logic                     clk,
    input  logic                     usb_rstn,
    // host link
    input  usb_serial_pkg::out_pkt_t pkt,
    output logic                     out_ack,
    // local receive side
    output usb_serial_pkg::byte_t    recv_data,
    output logic                     recv_valid
);

    //----------------------------------------------------------------------
    // toggle check
    //----------------------------------------------------------------------

    logic exp_tog;                              // toggle of next new packet
    logic tog_ok;                               // byte belongs to a new packet
    logic pkt_end;                              // final byte of any packet

    assign tog_ok  = pkt.valid && (pkt.toggle == exp_tog);
    assign pkt_end = pkt.valid && pkt.last;

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            exp_tog <= 1'b0;                    // DATA0 after reset
        end else if (tog_ok && pkt.last) begin
            exp_tog <= ~exp_tog;                // packet accepted
        end
    end

    //----------------------------------------------------------------------
    // handshake back to host
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            out_ack <= 1'b0;
        end else begin
            out_ack <= pkt_end;                 // stale toggle still gets ACK
        end
    end

    //----------------------------------------------------------------------
    // byte delivery
    //----------------------------------------------------------------------

    always_ff @(posedge clk or negedge usb_rstn) begin
        if (!usb_rstn) begin
            recv_valid <= 1'b0;
        end else begin
            recv_valid <= tog_ok;               // one-cycle strobe per new byte
        end
    end

    always_ff @(posedge clk) begin
        if (tog_ok) begin
            recv_data <= pkt.data;              // duplicates never reach here
        end
    end

endmodule

/* design/usb_serial_bridge.sv */
//--------------------------------------------------------------------------
// usb serial bridge
// byte-level data path of a full-speed CDC device: send buffer and IN
// packetizer toward the host, OUT receiver toward the local side
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module usb_serial_bridge (
    input  logic                     clk,
    input  logic                     usb_rstn,
    // local send side, device to host
    input  usb_serial_pkg::byte_t    send_data,
    input  logic                     send_valid,
    output logic                     send_ready,
    // local receive side, host to device
    output usb_serial_pkg::byte_t    recv_data,
    output logic                     recv_valid,
    // host link, IN endpoint
    input  usb_serial_pkg::in_host_t in_host,
    output usb_serial_pkg::in_rsp_t  in_rsp,
    // host link, OUT endpoint
    input  usb_serial_pkg::out_pkt_t out_pkt,
    output logic                     out_ack
);
    import usb_serial_pkg::*;

    //----------------------------------------------------------------------
    // buffer to packetizer
    //----------------------------------------------------------------------

    cnt_t  avail;                               // unread bytes
    byte_t rd_data;
    logic  rd_en;
    logic  rewind;                              // retry of unacked packet
    logic  commit;                              // host acked packet

    send_buffer u_send_buffer (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .send_data  (send_data),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rewind     (rewind),
        .commit     (commit),
        .avail      (avail)
    );

    in_packetizer u_in_packetizer (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .host       (in_host),
        .rsp        (in_rsp),
        .avail      (avail),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .rewind     (rewind),
        .commit     (commit)
    );

    out_receiver u_out_receiver (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .pkt        (out_pkt),
        .out_ack    (out_ack),
        .recv_data  (recv_data),
        .recv_valid (recv_valid)
    );

endmodule

/* sim/usb_serial_bridge_chk.sv */
//--------------------------------------------------------------------------
// IN link protocol checks
// concurrent assertions on the packetizer response, bound into the DUT
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module usb_serial_bridge_chk (
    input logic                     clk,
    input logic                     usb_rstn,
    input usb_serial_pkg::in_host_t host,
    input usb_serial_pkg::in_rsp_t  rsp
);

    a_nak_not_valid: assert property (@(posedge clk) disable iff (!usb_rstn)
        !(rsp.nak && rsp.valid))
        else $error("nak and valid high in the same cycle");

    a_toggle_stable: assert property (@(posedge clk) disable iff (!usb_rstn)
        rsp.valid && !rsp.last |=> $stable(rsp.toggle))
        else $error("toggle changed inside an IN packet");

    a_gap_after_last: assert property (@(posedge clk) disable iff (!usb_rstn)
        rsp.valid && rsp.last |=> !rsp.valid)
        else $error("valid still high after last byte");

    a_nak_after_tok: assert property (@(posedge clk) disable iff (!usb_rstn)
        rsp.nak |-> $past(host.in_tok))
        else $error("nak without IN token one cycle before");

endmodule

bind in_packetizer usb_serial_bridge_chk u_chk (
    .clk      (clk),
    .usb_rstn (usb_rstn),
    .host     (host),
    .rsp      (rsp)
);

/* sim/usb_serial_bridge_tb.sv */
//--------------------------------------------------------------------------
// usb serial bridge testbench
// host model for the IN and OUT links, reference model of the send buffer
// and both data toggles, and a process comparing every returned byte
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module usb_serial_bridge_tb;
    import usb_serial_pkg::*;

    localparam int DRV_DLY     = 2;             // input skew after rising edge
    localparam int TIMEOUT_CYC = 200;           // limit of each wait loop

    typedef struct packed {
        logic  last;
        logic  toggle;
        byte_t data;
    } exp_byte_t;

    logic      clk;
    logic      usb_rstn;
    byte_t     send_data;
    logic      send_valid;
    logic      send_ready;
    byte_t     recv_data;
    logic      recv_valid;
    in_host_t  in_host;
    in_rsp_t   in_rsp;
    out_pkt_t  out_pkt;
    logic      out_ack;

    int        seed = 34987;
    byte_t     ref_q[$];                        // uncommitted bytes, oldest first
    int        pend_len;                        // sent packet still waiting for ACK
    logic      in_tog;                          // model of IN toggle
    logic      out_tog;                         // model of expected OUT toggle
    exp_byte_t exp_in_q[$];
    byte_t     exp_recv_q[$];
    byte_t     last_out[$];                     // bytes of previous OUT packet
    exp_byte_t in_exp;
    byte_t     recv_exp;
    int        n_got;
    int        k;

    usb_serial_bridge dut0 (
        .clk        (clk),
        .usb_rstn   (usb_rstn),
        .send_data  (send_data),
        .send_valid (send_valid),
        .send_ready (send_ready),
        .recv_data  (recv_data),
        .recv_valid (recv_valid),
        .in_host    (in_host),
        .in_rsp     (in_rsp),
        .out_pkt    (out_pkt),
        .out_ack    (out_ack)
    );

    always #10 clk = ~clk;                      // 20 ns period

    //----------------------------------------------------------------------
    // checking helpers and reference model
    //----------------------------------------------------------------------

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR at %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT_CYC);
        $display("FAIL: see errors above");
        $fatal(1, "wait timed out");
    endtask

    // packet length a token should get, 0 means NAK
    function automatic int expected_len();
        if (pend_len != 0) begin
            return pend_len;                    // retry, same bytes
        end
        if (ref_q.size() > MAX_PKT) begin
            return MAX_PKT;
        end
        return ref_q.size();
    endfunction

    // host ACK frees the packet and flips the toggle
    function automatic void commit_model();
        for (int i = 0; i < pend_len; i++) begin
            void'(ref_q.pop_front());
        end
        pend_len = 0;
        in_tog   = ~in_tog;
    endfunction

    //----------------------------------------------------------------------
    // host and local side drivers
    //----------------------------------------------------------------------

    task automatic write_bytes(input int n);
        byte_t b;
        logic  exp_rdy;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #DRV_DLY;
            b       = byte_t'($random(seed));
            exp_rdy = (ref_q.size() < (1 << ASIZE));       // full at 1024 unacked
            check_val("send_ready", 32'(send_ready), 32'(exp_rdy));
            send_data  = b;
            send_valid = 1'b1;
            if (exp_rdy) begin
                ref_q.push_back(b);
            end
        end
        @(posedge clk);
        #DRV_DLY;
        send_valid = 1'b0;
    endtask

    // one IN token, optional ACK; returns number of bytes seen
    task automatic in_transfer(input bit do_ack, output int got);
        exp_byte_t ent;
        int        len;
        int        lat;
        len = expected_len();
        for (int i = 0; i < len; i++) begin
            ent.last   = (i == len - 1);
            ent.toggle = in_tog;
            ent.data   = ref_q[i];
            exp_in_q.push_back(ent);
        end
        pend_len = len;
        @(posedge clk);
        #DRV_DLY;
        in_host.in_tok = 1'b1;
        @(posedge clk);
        #DRV_DLY;
        in_host.in_tok = 1'b0;
        lat = 0;
        do begin                                // first answer from DUT
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT_CYC) begin
                timeout_fail("answer to IN token");
            end
        end while (!(in_rsp.nak || in_rsp.valid));
        if (len == 0) begin
            check_val("nak latency", lat, 1);
            check_val("nak", 32'(in_rsp.nak), 1);
            got = 0;
        end else begin
            check_val("first byte latency", lat, 2);
            got = 1;
            while (!in_rsp.last) begin
                @(negedge clk);
                got++;
                check_val("valid inside packet", 32'(in_rsp.valid), 1);
                if (got > TIMEOUT_CYC) begin
                    timeout_fail("last byte of IN packet");
                end
            end
            check_val("IN packet length", got, len);
            if (do_ack) begin
                @(posedge clk);
                #DRV_DLY;
                in_host.in_ack = 1'b1;
                @(posedge clk);
                #DRV_DLY;
                in_host.in_ack = 1'b0;
                commit_model();
            end
        end
    endtask

    // one OUT packet, new random bytes or the previous ones again
    task automatic out_packet(input int len, input logic tog, input bit resend);
        byte_t b;
        logic  fresh;
        int    lat;
        fresh = (tog == out_tog);
        if (!resend) begin
            last_out.delete();
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            #DRV_DLY;
            if (resend) begin
                b = last_out[i];
            end else begin
                b = byte_t'($random(seed));
                last_out.push_back(b);
            end
            out_pkt.valid  = 1'b1;
            out_pkt.last   = (i == len - 1);
            out_pkt.toggle = tog;
            out_pkt.data   = b;
            if (fresh) begin
                exp_recv_q.push_back(b);        // stale toggle delivers nothing
            end
        end
        @(posedge clk);
        #DRV_DLY;
        out_pkt = '0;
        lat     = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT_CYC) begin
                timeout_fail("out_ack after OUT packet");
            end
        end while (!out_ack);
        check_val("out_ack latency", lat, 1);
        if (fresh) begin
            out_tog = ~out_tog;
        end
    endtask

    //----------------------------------------------------------------------
    // comparison of every IN byte and every recv strobe
    //----------------------------------------------------------------------

    always @(negedge clk) begin
        if (usb_rstn && in_rsp.valid) begin
            check_val("in_rsp byte was expected", 32'(exp_in_q.size() != 0), 1);
            in_exp = exp_in_q.pop_front();
            check_val("in_rsp.data", 32'(in_rsp.data), 32'(in_exp.data));
            check_val("in_rsp.toggle", 32'(in_rsp.toggle), 32'(in_exp.toggle));
            check_val("in_rsp.last", 32'(in_rsp.last), 32'(in_exp.last));
        end
        if (usb_rstn && recv_valid) begin
            check_val("recv byte was expected", 32'(exp_recv_q.size() != 0), 1);
            recv_exp = exp_recv_q.pop_front();
            check_val("recv_data", 32'(recv_data), 32'(recv_exp));
        end
    end

    //----------------------------------------------------------------------
    // test sequence
    //----------------------------------------------------------------------

    initial begin
        clk        = 1'b0;
        usb_rstn   = 1'b0;
        send_data  = '0;
        send_valid = 1'b0;
        in_host    = '0;
        out_pkt    = '0;
        pend_len   = 0;
        in_tog     = 1'b0;                      // DATA0 after reset
        out_tog    = 1'b0;
        repeat (4) @(posedge clk);
        #DRV_DLY;
        usb_rstn = 1'b1;

        // reset values, then NAK on empty buffer
        @(posedge clk);
        #DRV_DLY;
        check_val("send_ready after reset", 32'(send_ready), 1);
        check_val("nak after reset", 32'(in_rsp.nak), 0);
        check_val("valid after reset", 32'(in_rsp.valid), 0);
        check_val("last after reset", 32'(in_rsp.last), 0);
        check_val("out_ack after reset", 32'(out_ack), 0);
        check_val("recv_valid after reset", 32'(recv_valid), 0);
        in_transfer(1'b1, n_got);

        // short packet, ACK, then NAK
        write_bytes(5);
        in_transfer(1'b1, n_got);
        check_val("5 byte packet", n_got, 5);
        in_transfer(1'b1, n_got);

        // retry without ACK repeats packet and toggle
        write_bytes(10);
        in_transfer(1'b0, n_got);
        in_transfer(1'b1, n_got);
        write_bytes(3);
        in_transfer(1'b1, n_got);

        // 70 bytes split into 32, 32, 6
        write_bytes(70);
        in_transfer(1'b1, n_got);
        check_val("1st of 70", n_got, 32);
        in_transfer(1'b1, n_got);
        check_val("2nd of 70", n_got, 32);
        in_transfer(1'b1, n_got);
        check_val("3rd of 70", n_got, 6);

        // full buffer, ACK frees space, then drain across the wrap
        write_bytes(1 << ASIZE);
        check_val("send_ready when full", 32'(send_ready), 0);
        write_bytes(1);                         // refused while full
        in_transfer(1'b1, n_got);
        check_val("send_ready after ACK", 32'(send_ready), 1);
        while (ref_q.size() != 0) begin
            in_transfer(1'b1, n_got);
        end
        in_transfer(1'b1, n_got);               // empty again, NAK

        // OUT packets with alternating toggles
        for (k = 0; k < 4; k++) begin
            out_packet(1 + ($random(seed) & 15), k[0], 1'b0);
        end

        // stale toggle repeat is dropped, next fresh packet delivered
        out_packet(last_out.size(), 1'b1, 1'b1);
        out_packet(1 + ($random(seed) & 15), 1'b0, 1'b0);

        repeat (4) @(posedge clk);
        if (exp_in_q.size() == 0 && exp_recv_q.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("expected bytes never came out of the DUT");
            $display("FAIL: see errors above");
            $fatal(1, "bytes missing");
        end
    end

endmodule

/* usb_serial_bridge.f */
common/usb_serial_pkg.sv
design/send_buffer.sv
design/in_packetizer.sv
design/out_receiver.sv
design/usb_serial_bridge.sv
sim/usb_serial_bridge_chk.sv
sim/usb_serial_bridge_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the usb serial bridge testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --top-module usb_serial_bridge_tb \
    -f usb_serial_bridge.f \
    -Mdir obj_dir \
    -o usb_serial_bridge_sim \
    && ./obj_dir/usb_serial_bridge_sim \
    || { echo "usb_serial_bridge simulation failed"; exit 1; }
echo "usb_serial_bridge simulation passed"
